/* usart_config.svh */
`ifndef USART_CONFIG_SVH
`define USART_CONFIG_SVH

// data memory addresses of the usart registers
`define USART_UDR_ADDR    12'h0C6
`define USART_UCSRA_ADDR  12'h0C0
`define USART_UCSRB_ADDR  12'h0C1
`define USART_UCSRC_ADDR  12'h0C2
`define USART_UBRRH_ADDR  12'h0C5
`define USART_UBRRL_ADDR  12'h0C4

// interrupt vector numbers, matched against irqack_addr_i
`define USART_RXC_VEC   6'h12
`define USART_UDRE_VEC  6'h13
`define USART_TXC_VEC   6'h14

// prescaler ticks per bit
`define USART_OSR_NORMAL  16
`define USART_OSR_U2X     8

`define USART_UCSRC_RESET  8'h06  // 8 data bits, no parity, 1 stop

`endif

/* usart_pkg.sv */
package usart_pkg;

	typedef logic [7:0] usart_byte_t;

	// ucsz1:0 from ucsrc[2:1]
	typedef enum logic [1:0] {
		CS_5 = 2'b00,
		CS_6 = 2'b01,
		CS_7 = 2'b10,
		CS_8 = 2'b11
	} char_size_t;

	// upm1:0 from ucsrc[5:4], 01 is reserved and acts as none
	typedef enum logic [1:0] {
		PAR_NONE = 2'b00,
		PAR_RSVD = 2'b01,
		PAR_EVEN = 2'b10,
		PAR_ODD  = 2'b11
	} parity_t;

	// one receive fifo slot
	typedef struct packed {
		logic        fe;   // stop bit read low
		logic        upe;  // parity mismatch
		usart_byte_t data; // right aligned
	} rx_entry_t;

	typedef logic [11:0] ubrr_t;

endpackage

/* usart_baud.sv */
`timescale 1ns/1ns

module usart_baud (
	input  logic             cp2,
	input  logic             ireset,
	input  usart_pkg::ubrr_t ubrr_i,
	input  logic             en_i,
	input  logic             restart_i,
	input  logic             load_i,
	output logic             tick_o
);

	usart_pkg::ubrr_t cnt;
	logic             hold;

	assign hold = restart_i || load_i;

	// down counter, one tick per ubrr+1 clocks
	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			cnt <= '0;
		end else if (hold || (cnt == '0)) begin
			cnt <= ubrr_i;
		end else begin
			cnt <= cnt - 1'b1;
		end
	end

	assign tick_o = en_i && !hold && (cnt == '0);  // reload cycle

endmodule

/* usart_fifo.sv */
`timescale 1ns/1ns

module usart_fifo #(
	parameter type payload_t = usart_pkg::usart_byte_t,
	parameter int  DEPTH     = 2
) (
	input  logic     cp2,
	input  logic     ireset,
	input  payload_t din_i,
	input  logic     we_i,
	input  logic     re_i,
	input  logic     flush_i,
	output payload_t dout_o,
	output logic     full_o,
	output logic     empty_o
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	payload_t        mem [DEPTH];
	logic [AW-1:0]   wptr;
	logic [AW-1:0]   rptr;
	logic [CW-1:0]   count;
	logic            do_wr;
	logic            do_rd;

	assign full_o  = (count == CW'(DEPTH));
	assign empty_o = (count == '0);
	assign do_wr   = we_i && !full_o;  // dropped when full
	assign do_rd   = re_i && !empty_o;
	assign dout_o  = mem[rptr];        // head shows without a read

	always_ff @(posedge cp2) begin
		if (do_wr)
			mem[wptr] <= din_i;
	end

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			wptr  <= '0;
			rptr  <= '0;
			count <= '0;
		end else if (flush_i) begin
			wptr  <= '0;
			rptr  <= '0;
			count <= '0;
		end else begin
			if (do_wr)
				wptr <= (wptr == AW'(DEPTH - 1)) ? '0 : wptr + 1'b1;
			if (do_rd)
				rptr <= (rptr == AW'(DEPTH - 1)) ? '0 : rptr + 1'b1;
			if (do_wr && !do_rd)
				count <= count + 1'b1;
			else if (do_rd && !do_wr)
				count <= count - 1'b1;
		end
	end

endmodule

/* usart_rx.sv */
`timescale 1ns/1ns
`include "usart_config.svh"

module usart_rx (
	input  logic                  cp2,
	input  logic                  ireset,
	input  logic                  rxd_i,
	input  logic                  tick_i,
	input  logic                  en_i,
	input  logic                  u2x_i,
	input  usart_pkg::char_size_t char_size_i,
	input  usart_pkg::parity_t    parity_i,
	output logic                  restart_o,
	output logic                  wr_o,
	output usart_pkg::rx_entry_t  entry_o
);

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA} rx_state_t;

	rx_state_t  state;
	logic [2:0] rxd_sync;  // two sync flops plus edge history
	logic       rxd_q;
	logic [1:0] samp;
	logic       maj;
	logic [3:0] tick_cnt;
	logic [3:0] last_tick;
	logic [3:0] eval_tick;
	logic [3:0] bitcnt;
	logic [3:0] nbits;
	logic       par_en;
	logic [9:0] shreg;
	logic       eval;
	logic [7:0] raw;
	logic [7:0] data;

	assign rxd_q     = rxd_sync[1];
	assign nbits     = 4'd5 + {2'b00, char_size_i};
	assign par_en    = parity_i[1];
	assign last_tick = u2x_i ? 4'(`USART_OSR_U2X - 1) : 4'(`USART_OSR_NORMAL - 1);
	assign eval_tick = u2x_i ? 4'(`USART_OSR_U2X / 2 + 1) : 4'(`USART_OSR_NORMAL / 2 + 1);
	assign eval      = tick_i && (tick_cnt == eval_tick);  // third mid-bit sample
	assign maj       = (samp[1] & samp[0]) | (samp[1] & rxd_q) | (samp[0] & rxd_q);
	assign restart_o = (state == RX_IDLE);

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset)
			rxd_sync <= 3'b111;  // line idles high
		else
			rxd_sync <= {rxd_sync[1:0], rxd_i};
	end

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			state    <= RX_IDLE;
			tick_cnt <= '0;
			bitcnt   <= '0;
			samp     <= 2'b11;
			wr_o     <= 1'b0;
		end else begin
			wr_o <= 1'b0;
			if (!en_i || state == RX_IDLE) begin
				tick_cnt <= '0;
				state    <= RX_IDLE;
				if (en_i && rxd_sync[2] && !rxd_q)  // falling edge
					state <= RX_START;
			end else if (tick_i) begin
				tick_cnt <= (tick_cnt == last_tick) ? 4'd0 : tick_cnt + 4'd1;
				samp     <= {samp[0], rxd_q};
				if (eval && state == RX_START) begin
					if (maj) begin
						state <= RX_IDLE;  // glitch, not a start bit
					end else begin
						state  <= RX_DATA;
						bitcnt <= nbits + {3'b000, par_en} + 4'd1;
					end
				end else if (eval) begin
					bitcnt <= bitcnt - 4'd1;
					if (bitcnt == 4'd1) begin  // stop bit
						state <= RX_IDLE;
						wr_o  <= 1'b1;
					end
				end
			end
		end
	end

	// bits enter at the top, so the stop bit ends in shreg[9]
	always_ff @(posedge cp2) begin
		if (state == RX_DATA && eval)
			shreg <= {maj, shreg[9:1]};
	end

	always_comb begin
		raw           = par_en ? shreg[7:0] : shreg[8:1];
		data          = raw >> (4'd8 - nbits);
		entry_o.data  = data;
		entry_o.fe    = !shreg[9];
		entry_o.upe   = par_en && (^data ^ shreg[8] ^ parity_i[0]);
	end

endmodule

/* usart_tx.sv */
`timescale 1ns/1ns
`include "usart_config.svh"

module usart_tx (
	input  logic                   cp2,
	input  logic                   ireset,
	input  logic                   tick_i,
	input  logic                   en_i,
	input  logic                   u2x_i,
	input  usart_pkg::char_size_t  char_size_i,
	input  usart_pkg::parity_t     parity_i,
	input  logic                   two_stop_i,
	input  usart_pkg::usart_byte_t data_i,
	input  logic                   buf_empty_i,
	output logic                   pop_o,
	output logic                   restart_o,
	output logic                   done_o,
	output logic                   txd_o
);

	logic [3:0]  bitcnt;    // bits left, zero means idle
	logic [3:0]  tick_cnt;
	logic [3:0]  last_tick;
	logic [3:0]  nbits;
	logic [3:0]  frame_len;
	logic        par_en;
	logic        par_bit;
	logic        bit_end;
	logic [11:0] frame;
	logic [11:0] shreg;

	assign nbits     = 4'd5 + {2'b00, char_size_i};
	assign par_en    = parity_i[1];
	assign last_tick = u2x_i ? 4'(`USART_OSR_U2X - 1) : 4'(`USART_OSR_NORMAL - 1);
	assign frame_len = 4'd2 + nbits + {3'b000, par_en} + {3'b000, two_stop_i};
	assign bit_end   = (bitcnt != '0) && tick_i && (tick_cnt == last_tick);
	assign pop_o     = en_i && (bitcnt == '0) && !buf_empty_i;
	assign restart_o = (bitcnt == '0);
	assign txd_o     = (bitcnt == '0 || !en_i) ? 1'b1 : shreg[0];

	// start, data lsb first, parity, then ones for the stop bits
	always_comb begin
		frame   = '1;
		par_bit = parity_i[0];  // odd parity starts from one
		frame[0] = 1'b0;
		for (int i = 0; i < 8; i++) begin
			if (i < nbits) begin
				frame[i+1] = data_i[i];
				par_bit    = par_bit ^ data_i[i];
			end
		end
		if (par_en)
			frame[nbits+1] = par_bit;
	end

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			bitcnt   <= '0;
			tick_cnt <= '0;
			done_o   <= 1'b0;
		end else begin
			done_o <= 1'b0;
			if (!en_i) begin
				bitcnt   <= '0;  // abort the frame
				tick_cnt <= '0;
			end else if (pop_o) begin
				bitcnt   <= frame_len;
				tick_cnt <= '0;
			end else if (bit_end) begin
				tick_cnt <= '0;
				bitcnt   <= bitcnt - 4'd1;
				done_o   <= (bitcnt == 4'd1);  // last stop bit out
			end else if (bitcnt != '0 && tick_i) begin
				tick_cnt <= tick_cnt + 4'd1;
			end
		end
	end

	always_ff @(posedge cp2) begin
		if (pop_o)
			shreg <= frame;
		else if (bit_end)
			shreg <= {1'b1, shreg[11:1]};
	end

endmodule

/* usart_regs.sv */
`timescale 1ns/1ns
`include "usart_config.svh"

module usart_regs (
	input  logic                   cp2,
	input  logic                   ireset,
	input  logic [11:0]            ram_addr_i,
	input  logic                   ramre_i,
	input  logic                   ramwe_i,
	input  usart_pkg::usart_byte_t dbus_i,
	output usart_pkg::usart_byte_t dbus_o,
	output logic                   out_en_o,
	input  logic                   irqack_i,
	input  logic [5:0]             irqack_addr_i,
	input  usart_pkg::rx_entry_t   rx_head_i,
	input  logic                   rx_empty_i,
	input  logic                   rx_full_i,
	input  logic                   rx_wr_i,
	input  logic                   tx_full_i,
	input  logic                   tx_empty_i,
	input  logic                   tx_done_i,
	output logic                   rx_pop_o,
	output logic                   rx_flush_o,
	output logic                   tx_push_o,
	output logic                   rxen_o,
	output logic                   txen_o,
	output logic                   u2x_o,
	output usart_pkg::char_size_t  char_size_o,
	output usart_pkg::parity_t     parity_o,
	output logic                   two_stop_o,
	output usart_pkg::ubrr_t       ubrr_o,
	output logic                   baud_load_o,
	output logic                   rxc_irq_o,
	output logic                   udre_irq_o,
	output logic                   txc_irq_o
);

	logic [7:3]             ucsrb_q;  // rxcie txcie udrie rxen txen
	logic [7:0]             ucsrc_q;
	logic [3:0]             ubrrh_q;  // high byte waits here for the low byte
	usart_pkg::ubrr_t       ubrr_q;
	logic                   u2x_q;
	logic                   txc_q;
	logic                   dor_q;
	logic                   ucsra_we;
	logic                   txc_ack;
	usart_pkg::usart_byte_t ucsra;

	assign ucsra_we = ramwe_i && (ram_addr_i == `USART_UCSRA_ADDR);
	assign txc_ack  = irqack_i && (irqack_addr_i == `USART_TXC_VEC);

	assign rxen_o      = ucsrb_q[4];
	assign txen_o      = ucsrb_q[3];
	assign u2x_o       = u2x_q;
	assign char_size_o = usart_pkg::char_size_t'(ucsrc_q[2:1]);
	assign parity_o    = usart_pkg::parity_t'(ucsrc_q[5:4]);
	assign two_stop_o  = ucsrc_q[3];
	assign ubrr_o      = ubrr_q;

	// datapath strobes
	assign rx_pop_o    = ramre_i && (ram_addr_i == `USART_UDR_ADDR) && rxen_o;
	assign tx_push_o   = ramwe_i && (ram_addr_i == `USART_UDR_ADDR) && txen_o;
	assign rx_flush_o  = ramwe_i && (ram_addr_i == `USART_UCSRB_ADDR) && !dbus_i[4];
	assign baud_load_o = ramwe_i && (ram_addr_i == `USART_UBRRL_ADDR);

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			ucsrb_q <= '0;
			ucsrc_q <= `USART_UCSRC_RESET;
			ubrrh_q <= '0;
			ubrr_q  <= '0;
			u2x_q   <= 1'b0;
		end else if (ramwe_i) begin
			case (ram_addr_i)
				`USART_UCSRA_ADDR: u2x_q <= dbus_i[1];
				`USART_UCSRB_ADDR: ucsrb_q <= dbus_i[7:3];
				`USART_UCSRC_ADDR: ucsrc_q <= dbus_i;
				`USART_UBRRH_ADDR: ubrrh_q <= dbus_i[3:0];
				`USART_UBRRL_ADDR: ubrr_q <= {ubrrh_q, dbus_i}; // commit both halves
				default: ;
			endcase
		end
	end

	// status flags, a set wins over a clear in the same cycle
	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			txc_q <= 1'b0;
			dor_q <= 1'b0;
		end else begin
			if (tx_done_i && tx_empty_i)
				txc_q <= 1'b1;
			else if (txc_ack || (ucsra_we && dbus_i[6]))
				txc_q <= 1'b0;
			if (rx_wr_i && rx_full_i)
				dor_q <= 1'b1;  // character lost
			else if (rx_pop_o || ucsra_we)
				dor_q <= 1'b0;
		end
	end

	always_comb begin
		ucsra = {!rx_empty_i, txc_q, !tx_full_i,
			!rx_empty_i && rx_head_i.fe, dor_q,
			!rx_empty_i && rx_head_i.upe, u2x_q, 1'b0}; // mpcm reads 0
	end

	always_comb begin
		dbus_o   = '0;
		out_en_o = ramre_i;
		case (ram_addr_i)
			`USART_UDR_ADDR:   dbus_o = rx_head_i.data;
			`USART_UCSRA_ADDR: dbus_o = ucsra;
			`USART_UCSRB_ADDR: dbus_o = {ucsrb_q, 3'b000};
			`USART_UCSRC_ADDR: dbus_o = ucsrc_q;
			`USART_UBRRH_ADDR: dbus_o = {4'h0, ubrr_q[11:8]};
			`USART_UBRRL_ADDR: dbus_o = ubrr_q[7:0];
			default:           out_en_o = 1'b0;
		endcase
	end

	assign rxc_irq_o  = ucsrb_q[7] && !rx_empty_i;
	assign txc_irq_o  = ucsrb_q[6] && txc_q;
	assign udre_irq_o = ucsrb_q[5] && !tx_full_i;

endmodule

/* usart_top.sv */
`timescale 1ns/1ns

module usart_top (
	input  logic                   cp2,
	input  logic                   ireset,
	input  logic [11:0]            ram_addr_i,
	input  logic                   ramre_i,
	input  logic                   ramwe_i,
	input  usart_pkg::usart_byte_t dbus_i,
	output usart_pkg::usart_byte_t dbus_o,
	output logic                   out_en_o,
	input  logic                   rxd_i,
	output logic                   txd_o,
	output logic                   rxen_o,
	output logic                   txen_o,
	output logic                   rxc_irq_o,
	output logic                   udre_irq_o,
	output logic                   txc_irq_o,
	input  logic                   irqack_i,
	input  logic [5:0]             irqack_addr_i
);

	usart_pkg::rx_entry_t   rx_entry, rx_head;
	usart_pkg::usart_byte_t tx_data;
	usart_pkg::char_size_t  char_size;
	usart_pkg::parity_t     parity;
	usart_pkg::ubrr_t       ubrr;
	logic rx_wr, rx_pop, rx_flush, rx_full, rx_empty, rx_restart, rx_tick;
	logic tx_push, tx_pop, tx_full, tx_empty, tx_restart, tx_tick, tx_done;
	logic u2x, two_stop, baud_load;

	usart_regs regs0 (.cp2, .ireset, .ram_addr_i, .ramre_i, .ramwe_i, .dbus_i, .dbus_o,
		.out_en_o, .irqack_i, .irqack_addr_i, .rx_head_i(rx_head), .rx_empty_i(rx_empty),
		.rx_full_i(rx_full), .rx_wr_i(rx_wr), .tx_full_i(tx_full), .tx_empty_i(tx_empty),
		.tx_done_i(tx_done), .rx_pop_o(rx_pop), .rx_flush_o(rx_flush), .tx_push_o(tx_push),
		.rxen_o, .txen_o, .u2x_o(u2x), .char_size_o(char_size), .parity_o(parity),
		.two_stop_o(two_stop), .ubrr_o(ubrr), .baud_load_o(baud_load),
		.rxc_irq_o, .udre_irq_o, .txc_irq_o);

	usart_baud baud_rx0 (.cp2, .ireset, .ubrr_i(ubrr), .en_i(rxen_o),
		.restart_i(rx_restart), .load_i(baud_load), .tick_o(rx_tick));

	usart_baud baud_tx0 (.cp2, .ireset, .ubrr_i(ubrr), .en_i(txen_o),
		.restart_i(tx_restart), .load_i(baud_load), .tick_o(tx_tick));

	usart_fifo #(.payload_t(usart_pkg::rx_entry_t), .DEPTH(2)) rx_fifo0 (.cp2, .ireset,
		.din_i(rx_entry), .we_i(rx_wr), .re_i(rx_pop), .flush_i(rx_flush),
		.dout_o(rx_head), .full_o(rx_full), .empty_o(rx_empty));

	usart_fifo #(.payload_t(usart_pkg::usart_byte_t), .DEPTH(1)) tx_buf0 (.cp2, .ireset,
		.din_i(dbus_i), .we_i(tx_push), .re_i(tx_pop), .flush_i(!txen_o),
		.dout_o(tx_data), .full_o(tx_full), .empty_o(tx_empty));

	usart_rx rx0 (.cp2, .ireset, .rxd_i, .tick_i(rx_tick), .en_i(rxen_o), .u2x_i(u2x),
		.char_size_i(char_size), .parity_i(parity), .restart_o(rx_restart),
		.wr_o(rx_wr), .entry_o(rx_entry));

	usart_tx tx0 (.cp2, .ireset, .tick_i(tx_tick), .en_i(txen_o), .u2x_i(u2x),
		.char_size_i(char_size), .parity_i(parity), .two_stop_i(two_stop),
		.data_i(tx_data), .buf_empty_i(tx_empty), .pop_o(tx_pop),
		.restart_o(tx_restart), .done_o(tx_done), .txd_o);

endmodule

/* tb_usart_asserts.sv */
`timescale 1ns/1ns

module tb_usart_asserts (
	input logic cp2,
	input logic ireset,
	input logic ramre_i,
	input logic out_en_i,
	input logic txen_i,
	input logic txd_i,
	input logic rxc_irq_i,
	input logic udre_irq_i,
	input logic txc_irq_i
);

	// read data reaches the bus only during a read
	read_enable_a: assert property (@(posedge cp2) out_en_i |-> ramre_i)
		else $error("out_en_o high without ramre_i");

	irq_reset_a: assert property (@(posedge cp2)
		!ireset |-> !(rxc_irq_i || udre_irq_i || txc_irq_i))
		else $error("interrupt output high during reset");

	txd_idle_a: assert property (@(posedge cp2) !txen_i |-> txd_i)  // line idles high
		else $error("txd_o low while the transmitter is disabled");

endmodule

bind usart_top tb_usart_asserts asserts0 (
	.cp2(cp2),
	.ireset(ireset),
	.ramre_i(ramre_i),
	.out_en_i(out_en_o),
	.txen_i(txen_o),
	.txd_i(txd_o),
	.rxc_irq_i(rxc_irq_o),
	.udre_irq_i(udre_irq_o),
	.txc_irq_i(txc_irq_o)
);

/* tb_usart.sv */
`timescale 1ns/1ns
`include "usart_config.svh"

module tb_usart;

	localparam int BIT_CYC = 32;  // ubrr 1, 16 ticks per bit
	localparam int FRAMES  = 16;  // tx and rx frames over all tests
	localparam int LIMIT   = FRAMES * 13 * BIT_CYC + 3000;

	logic                   cp2;
	logic                   ireset;
	logic [11:0]            ram_addr_i;
	logic                   ramre_i;
	logic                   ramwe_i;
	usart_pkg::usart_byte_t dbus_i;
	usart_pkg::usart_byte_t dbus_o;
	logic                   out_en_o;
	logic                   rxd_i;
	logic                   txd_o;
	logic                   rxen_o;
	logic                   txen_o;
	logic                   rxc_irq_o;
	logic                   udre_irq_o;
	logic                   txc_irq_o;
	logic                   irqack_i;
	logic [5:0]             irqack_addr_i;
	logic                   read_oe;  // out_en_o seen by the last bus read
	int                     cycles;

	usart_top dut0 (.*);

	initial begin
		cp2 = 1'b0;
		forever #4 cp2 = ~cp2;
	end

	initial begin
		cycles = 0;
		while (cycles < LIMIT) begin
			@(posedge cp2);
			cycles++;
		end
		$display(">>> FAIL");
		$fatal(1, "timeout after %0d cycles, the DUT stopped responding", cycles);
	end

	task automatic abort_run(input string why);
		$display(">>> FAIL");
		$fatal(1, "%s", why);
	endtask

	task automatic check_byte(input string name, input usart_pkg::usart_byte_t got,
		input usart_pkg::usart_byte_t exp);
		if (got !== exp) begin
			$display("error %s got %h expected %h", name, got, exp);
			abort_run({name, " mismatch"});
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("error %s got %h expected %h", name, got, exp);
			abort_run({name, " mismatch"});
		end
	endtask

	task automatic check_entry(input string name, input usart_pkg::rx_entry_t got,
		input usart_pkg::rx_entry_t exp);
		if (got !== exp) begin
			$display("error %s got %h expected %h", name, got, exp);
			abort_run({name, " mismatch"});
		end
	endtask

	function automatic usart_pkg::usart_byte_t rand_byte();
		return usart_pkg::usart_byte_t'($urandom());
	endfunction

	task automatic bus_write(input logic [11:0] addr, input usart_pkg::usart_byte_t data);
		@(posedge cp2);
		ram_addr_i <= addr;
		dbus_i     <= data;
		ramwe_i    <= 1'b1;
		@(posedge cp2);
		ramwe_i <= 1'b0;
	endtask

	task automatic bus_read(input logic [11:0] addr, output usart_pkg::usart_byte_t data);
		@(posedge cp2);
		ram_addr_i <= addr;
		ramre_i    <= 1'b1;
		@(negedge cp2);  // read mux is combinational
		data    = dbus_o;
		read_oe = out_en_o;
		@(posedge cp2);
		ramre_i <= 1'b0;
	endtask

	task automatic ack_vector(input logic [5:0] vec);
		@(posedge cp2);
		irqack_i      <= 1'b1;
		irqack_addr_i <= vec;
		@(posedge cp2);
		irqack_i <= 1'b0;
	endtask

	// poll one ucsra bit until it sets
	task automatic wait_status(input int bitpos, input string what);
		usart_pkg::usart_byte_t st;
		logic                   done;
		int                     n;
		done = 1'b0;
		for (n = 0; n < 200 && !done; n++) begin
			bus_read(`USART_UCSRA_ADDR, st);
			done = st[bitpos];
		end
		if (!done)
			abort_run({what, " flag never set"});
	endtask

	// uart line model, start bit then data lsb first
	task automatic send_frame(input usart_pkg::usart_byte_t data, input int nbits,
		input usart_pkg::parity_t par, input logic bad_par, input logic stop, input int bp);
		logic [11:0]            line;
		usart_pkg::usart_byte_t mask;
		int                     len;
		int                     i;
		mask    = 8'hff >> (8 - nbits);
		line    = '1;
		line[0] = 1'b0;
		for (i = 0; i < nbits; i++)
			line[i + 1] = data[i];
		len = nbits + 1;
		if (par[1]) begin
			line[len] = ^(data & mask) ^ par[0] ^ bad_par;
			len++;
		end
		line[len] = stop;
		len++;
		for (i = 0; i < len; i++) begin
			@(posedge cp2);
			rxd_i <= line[i];
			repeat (bp - 1) @(posedge cp2);
		end
		@(posedge cp2);
		rxd_i <= 1'b1;
		repeat (bp) @(posedge cp2);  // idle gap
	endtask

	task automatic recv_frame(input int len, output logic [11:0] line);
		int i;
		line = '1;
		@(negedge txd_o);
		repeat (BIT_CYC / 2) @(negedge cp2);
		line[0] = txd_o;
		for (i = 1; i < len; i++) begin
			repeat (BIT_CYC) @(negedge cp2);  // middle of each later bit
			line[i] = txd_o;
		end
	endtask

	task automatic check_frame(input logic [11:0] line, input usart_pkg::usart_byte_t data,
		input int nbits, input usart_pkg::parity_t par, input logic two_stop);
		usart_pkg::usart_byte_t mask;
		int                     k;
		mask = 8'hff >> (8 - nbits);
		check_bit("txd start bit", line[0], 1'b0);
		check_byte("txd data", usart_pkg::usart_byte_t'(line >> 1) & mask, data & mask);
		k = nbits + 1;
		if (par[1]) begin
			check_bit("txd parity bit", line[k], ^(data & mask) ^ par[0]);
			k++;
		end
		check_bit("txd stop bit", line[k], 1'b1);
		if (two_stop)
			check_bit("txd second stop bit", line[k + 1], 1'b1);
	endtask

	// second byte waits in the buffer while the first goes out
	task automatic send_pair(input usart_pkg::usart_byte_t b0, input usart_pkg::usart_byte_t b1,
		input int len, output logic [11:0] f0, output logic [11:0] f1);
		usart_pkg::usart_byte_t st;
		fork
			begin
				recv_frame(len, f0);
				recv_frame(len, f1);
			end
			begin
				bus_write(`USART_UDR_ADDR, b0);
				bus_write(`USART_UDR_ADDR, b1);
				bus_read(`USART_UCSRA_ADDR, st);
				check_bit("ucsra udre", st[5], 1'b0);
				@(negedge cp2);
				check_bit("udre_irq_o", udre_irq_o, 1'b0);
			end
		join
	endtask

	task automatic tx_config(input usart_pkg::usart_byte_t ucsrc, input int nbits,
		input usart_pkg::parity_t par, input logic two_stop);
		usart_pkg::usart_byte_t b0;
		usart_pkg::usart_byte_t b1;
		usart_pkg::usart_byte_t st;
		logic [11:0]            f0;
		logic [11:0]            f1;
		b0 = rand_byte();
		b1 = rand_byte();
		bus_write(`USART_UCSRC_ADDR, ucsrc);
		send_pair(b0, b1, 2 + nbits + int'(par[1]) + int'(two_stop), f0, f1);
		check_frame(f0, b0, nbits, par, two_stop);
		check_frame(f1, b1, nbits, par, two_stop);
		bus_read(`USART_UCSRA_ADDR, st);
		check_bit("ucsra txc in last stop bit", st[6], 1'b0);
		wait_status(6, "transmit complete");
		bus_write(`USART_UCSRA_ADDR, 8'h40);  // write one to clear
		bus_read(`USART_UCSRA_ADDR, st);
		check_bit("ucsra txc after clear", st[6], 1'b0);
	endtask

	task automatic expect_rx(input usart_pkg::usart_byte_t data, input logic fe,
		input logic upe);
		usart_pkg::usart_byte_t st;
		usart_pkg::usart_byte_t d;
		usart_pkg::rx_entry_t   got;
		usart_pkg::rx_entry_t   exp;
		wait_status(7, "receive complete");
		bus_read(`USART_UCSRA_ADDR, st);  // flags belong to the fifo head
		bus_read(`USART_UDR_ADDR, d);
		got = {st[4], st[2], d};
		exp = {fe, upe, data};
		check_entry("rx fifo head", got, exp);
	endtask

	task automatic test_reset();
		usart_pkg::usart_byte_t d;
		bus_read(`USART_UCSRA_ADDR, d);
		check_byte("ucsra", d, 8'h20);
		check_bit("out_en_o on ucsra", read_oe, 1'b1);
		bus_read(`USART_UCSRC_ADDR, d);
		check_byte("ucsrc", d, 8'h06);
		bus_read(`USART_UCSRB_ADDR, d);
		check_byte("ucsrb", d, 8'h00);
		bus_read(`USART_UBRRH_ADDR, d);
		check_byte("ubrrh", d, 8'h00);
		bus_read(`USART_UBRRL_ADDR, d);
		check_byte("ubrrl", d, 8'h00);
		bus_read(12'h0C3, d);  // unmapped
		check_bit("out_en_o on unmapped address", read_oe, 1'b0);
		check_bit("txd_o", txd_o, 1'b1);
		check_bit("rxen_o", rxen_o, 1'b0);
		check_bit("txen_o", txen_o, 1'b0);
	endtask

	task automatic test_baud_latch();
		usart_pkg::usart_byte_t d;
		bus_write(`USART_UBRRH_ADDR, 8'h03);
		bus_read(`USART_UBRRH_ADDR, d);
		check_byte("ubrrh before commit", d, 8'h00);
		bus_write(`USART_UBRRL_ADDR, 8'h45);
		bus_read(`USART_UBRRH_ADDR, d);
		check_byte("ubrrh after commit", d, 8'h03);
		bus_read(`USART_UBRRL_ADDR, d);
		check_byte("ubrrl after commit", d, 8'h45);
		bus_write(`USART_UBRRH_ADDR, 8'h00);
		bus_write(`USART_UBRRL_ADDR, 8'h01);  // two clocks per tick from here on
	endtask

	task automatic test_transmit();
		bus_write(`USART_UCSRB_ADDR, 8'h08);
		@(negedge cp2);
		check_bit("txen_o after enable", txen_o, 1'b1);
		check_bit("rxen_o with only txen", rxen_o, 1'b0);
		tx_config(8'h06, 8, usart_pkg::PAR_NONE, 1'b0);
		tx_config(8'h2C, 7, usart_pkg::PAR_EVEN, 1'b1);
		tx_config(8'h30, 5, usart_pkg::PAR_ODD, 1'b0);
	endtask

	task automatic test_receive();
		usart_pkg::usart_byte_t b;
		bus_write(`USART_UCSRB_ADDR, 8'h18);
		@(negedge cp2);
		check_bit("rxen_o after enable", rxen_o, 1'b1);
		bus_write(`USART_UCSRC_ADDR, 8'h26);  // 8e1
		b = rand_byte();
		send_frame(b, 8, usart_pkg::PAR_EVEN, 1'b0, 1'b1, BIT_CYC);
		expect_rx(b, 1'b0, 1'b0);
		b = rand_byte();
		send_frame(b, 8, usart_pkg::PAR_EVEN, 1'b1, 1'b1, BIT_CYC);
		expect_rx(b, 1'b0, 1'b1);
		b = rand_byte();
		send_frame(b, 8, usart_pkg::PAR_EVEN, 1'b0, 1'b0, BIT_CYC);
		expect_rx(b, 1'b1, 1'b0);
		bus_write(`USART_UCSRA_ADDR, 8'h02);  // u2x
		b = rand_byte();
		send_frame(b, 8, usart_pkg::PAR_EVEN, 1'b0, 1'b1, BIT_CYC / 2);
		expect_rx(b, 1'b0, 1'b0);
		bus_write(`USART_UCSRA_ADDR, 8'h00);
	endtask

	task automatic test_overrun();
		usart_pkg::usart_byte_t b0;
		usart_pkg::usart_byte_t b1;
		usart_pkg::usart_byte_t d;
		b0 = rand_byte();
		b1 = rand_byte();
		bus_write(`USART_UCSRC_ADDR, 8'h06);
		send_frame(b0, 8, usart_pkg::PAR_NONE, 1'b0, 1'b1, BIT_CYC);
		send_frame(b1, 8, usart_pkg::PAR_NONE, 1'b0, 1'b1, BIT_CYC);
		send_frame(rand_byte(), 8, usart_pkg::PAR_NONE, 1'b0, 1'b1, BIT_CYC);  // lost
		bus_read(`USART_UCSRA_ADDR, d);
		check_bit("ucsra dor", d[3], 1'b1);
		bus_read(`USART_UDR_ADDR, d);
		check_byte("udr first", d, b0);
		bus_read(`USART_UCSRA_ADDR, d);
		check_bit("ucsra dor after udr read", d[3], 1'b0);
		bus_read(`USART_UDR_ADDR, d);
		check_byte("udr second", d, b1);
		bus_read(`USART_UCSRA_ADDR, d);
		check_bit("ucsra rxc after drain", d[7], 1'b0);
	endtask

	task automatic test_interrupts();
		usart_pkg::usart_byte_t b;
		usart_pkg::usart_byte_t b1;
		usart_pkg::usart_byte_t d;
		logic [11:0]            f0;
		logic [11:0]            f1;
		b = rand_byte();
		bus_write(`USART_UCSRB_ADDR, 8'h90);
		@(negedge cp2);
		check_bit("rxc_irq_o while empty", rxc_irq_o, 1'b0);
		send_frame(b, 8, usart_pkg::PAR_NONE, 1'b0, 1'b1, BIT_CYC);
		wait_status(7, "receive complete");
		@(negedge cp2);
		check_bit("rxc_irq_o with data", rxc_irq_o, 1'b1);
		bus_write(`USART_UCSRB_ADDR, 8'h10);  // rxcie off, rxen kept
		@(negedge cp2);
		check_bit("rxc_irq_o without rxcie", rxc_irq_o, 1'b0);
		bus_write(`USART_UCSRB_ADDR, 8'h90);
		bus_read(`USART_UDR_ADDR, d);
		check_byte("udr", d, b);
		@(negedge cp2);
		check_bit("rxc_irq_o after read", rxc_irq_o, 1'b0);
		bus_write(`USART_UCSRB_ADDR, 8'h68);  // txcie udrie txen
		@(negedge cp2);
		check_bit("udre_irq_o while empty", udre_irq_o, 1'b1);
		check_bit("txc_irq_o before send", txc_irq_o, 1'b0);
		b  = rand_byte();
		b1 = rand_byte();
		send_pair(b, b1, 10, f0, f1);
		check_frame(f0, b, 8, usart_pkg::PAR_NONE, 1'b0);
		check_frame(f1, b1, 8, usart_pkg::PAR_NONE, 1'b0);
		wait_status(6, "transmit complete");
		@(negedge cp2);
		check_bit("txc_irq_o after send", txc_irq_o, 1'b1);
		ack_vector(`USART_TXC_VEC);
		@(negedge cp2);
		check_bit("txc_irq_o after acknowledge", txc_irq_o, 1'b0);
		bus_write(`USART_UCSRB_ADDR, 8'h48);
		@(negedge cp2);
		check_bit("udre_irq_o without udrie", udre_irq_o, 1'b0);
	endtask

	initial begin
		void'($urandom(32'hf5bd));
		ireset        = 1'b0;
		ram_addr_i    = '0;
		ramre_i       = 1'b0;
		ramwe_i       = 1'b0;
		dbus_i        = '0;
		rxd_i         = 1'b1;
		irqack_i      = 1'b0;
		irqack_addr_i = '0;
		read_oe       = 1'b0;
		repeat (4) @(posedge cp2);
		ireset <= 1'b1;
		test_reset();
		test_baud_latch();
		test_transmit();
		test_receive();
		test_overrun();
		test_interrupts();
		$display(">>> PASS");
		$finish;
	end

endmodule

/* sources.f */
+incdir+.
usart_pkg.sv
usart_baud.sv
usart_fifo.sv
usart_rx.sv
usart_tx.sv
usart_regs.sv
usart_top.sv
tb_usart_asserts.sv
tb_usart.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module tb_usart -o tb_usart
./obj_dir/tb_usart
